// ==== cmac_csb_pkg.sv ====
////////////////////////////////////////////////////////////
// csb request and response packet layout for the cmac regs
// byte enables, level and srcpriv are carried but not decoded
// field positions chain from addr upward, packet widths follow
////////////////////////////////////////////////////////////
`default_nettype none

package cmac_csb_pkg;

  localparam int csb_addr_w = 22;   // word address
  localparam int csb_data_w = 32;

  typedef logic [csb_addr_w-1:0] csb_addr_t;
  typedef logic [csb_data_w-1:0] csb_data_t;

  // request fields, lsb first
  localparam int req_addr_lsb    = 0;
  localparam int req_wdat_lsb    = req_addr_lsb + csb_addr_w;   // 22
  localparam int req_write_bit   = req_wdat_lsb + csb_data_w;   // 54
  localparam int req_nposted_bit = req_write_bit + 1;           // 55
  localparam int req_srcpriv_bit = req_nposted_bit + 1;         // 56, ignored
  localparam int req_wrbe_lsb    = req_srcpriv_bit + 1;         // 57, ignored
  localparam int req_wrbe_w      = 4;
  localparam int req_level_lsb   = req_wrbe_lsb + req_wrbe_w;   // 61, ignored
  localparam int req_level_w     = 2;
  localparam int csb_req_w       = req_level_lsb + req_level_w; // 63

  typedef logic [csb_req_w-1:0] csb_req_pd_t;

  // response: data, error, kind
  localparam int resp_error_bit = csb_data_w;       // 32
  localparam int resp_kind_bit  = resp_error_bit + 1;
  localparam int csb_resp_w     = resp_kind_bit + 1;

  typedef logic [csb_resp_w-1:0] csb_resp_pd_t;

  localparam logic resp_kind_read  = 1'b0;
  localparam logic resp_kind_write = 1'b1;

endpackage

`default_nettype wire

// ==== cmac_reg_pkg.sv ====
////////////////////////////////////////////////////////////
// cmac register map, field positions and status encoding
// only offset bits 11:0 are decoded, offsets below dual_base
// are the single group, the rest go to the producer group
////////////////////////////////////////////////////////////
`default_nettype none

package cmac_reg_pkg;

  typedef logic [11:0] reg_offset_t;   // byte offset in the 4KB window
  typedef logic [1:0]  precision_t;

  // register offsets
  localparam reg_offset_t ptr_offset       = 12'h000;
  localparam reg_offset_t status_offset    = 12'h004;
  localparam reg_offset_t op_enable_offset = 12'h008;
  localparam reg_offset_t misc_cfg_offset  = 12'h00c;

  // first offset of the ping-pong groups
  localparam reg_offset_t dual_base = 12'h008;

  // pointer register
  localparam int ptr_producer_bit = 0;    // rw
  localparam int ptr_consumer_bit = 16;   // ro

  // status register, one 2-bit field per group
  localparam int status_0_lsb = 0;
  localparam int status_1_lsb = 16;

  // op_enable register
  localparam int op_enable_bit = 0;

  // misc_cfg register
  localparam int cfg_conv_mode_bit = 0;
  localparam int cfg_prec_lsb      = 12;

  // op_en to datapath latency, also the clock gate delay
  localparam int op_en_lat = 3;

  typedef enum logic [1:0] {
    status_idle    = 2'd0,
    status_running = 2'd1,
    status_pending = 2'd2
  } group_status_e;

endpackage

`default_nettype wire

// ==== cmac_csb_port.sv ====
////////////////////////////////////////////////////////////
// csb slave side of the cmac register block
// always ready, one request per cycle, no back-pressure
// response goes out one cycle after the access, error is 0
// posted writes get no response
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmac_csb_port
  import cmac_csb_pkg::*;
  import cmac_reg_pkg::*;
(
  input  logic         nvdla_core_clk,
  input  logic         nvdla_core_rstn,
  input  csb_req_pd_t  csb_req_pd,
  input  logic         csb_req_pvld,
  input  csb_data_t    reg_rd_data,     // same-cycle readback
  output csb_resp_pd_t csb_resp_pd,
  output logic         csb_resp_valid,
  output reg_offset_t  reg_offset,
  output csb_data_t    reg_wr_data,
  output logic         reg_wr_en,
  output logic         reg_rd_en
);

  logic         req_pvld;      // registered strobe
  csb_req_pd_t  req_pd;        // captured packet
  csb_addr_t    req_addr;
  logic         req_write;
  logic         req_nposted;
  csb_resp_pd_t rresp_pd;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  // packet only loads on a valid beat
  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req_pd;
    end
  end

  // unpack, the rest of the packet is dropped
  assign req_addr    = req_pd[req_addr_lsb +: csb_addr_w];
  assign reg_wr_data = req_pd[req_wdat_lsb +: csb_data_w];
  assign req_write   = req_pd[req_write_bit];
  assign req_nposted = req_pd[req_nposted_bit];

  // word address to byte offset, keep 12 bits
  assign reg_offset = {req_addr[$bits(reg_offset_t)-3:0], 2'b00};
  assign reg_wr_en  = req_pvld & req_write;
  assign reg_rd_en  = req_pvld & ~req_write;

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////
  assign rresp_pd = {resp_kind_read, 1'b0, reg_rd_data};     // kind, error, data

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_pd <= '0;
    end else if (reg_rd_en) begin
      csb_resp_pd <= rresp_pd;
    end else if (reg_wr_en && req_nposted) begin
      csb_resp_pd <= {resp_kind_write, 1'b0, {csb_data_w{1'b0}}};   // write ack, no data
    end   // else hold
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= reg_rd_en | (reg_wr_en & req_nposted);
    end
  end

  // bus master must never float the strobe
  a_req_pvld_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(csb_req_pvld)
  ) else $error("csb_req_pvld is X");

  // a response always traces back to a request one cycle earlier
  a_resp_has_req : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> $past(req_pvld)
  ) else $error("csb_resp_valid without a registered request");

endmodule

`default_nettype wire

// ==== cmac_reg_groups.sv ====
////////////////////////////////////////////////////////////
// single register group plus the two ping-pong groups
// producer picks the group seen at dual offsets, consumer
// picks the group driven to the datapath
// a group is write locked while its op_en is set
// unmapped offsets read 0 and drop writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmac_reg_groups
  import cmac_csb_pkg::*;
  import cmac_reg_pkg::*;
(
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  reg_offset_t reg_offset,
  input  csb_data_t   reg_wr_data,
  input  logic        reg_wr_en,
  input  logic        reg_rd_en,
  input  logic        op_en_0,
  input  logic        op_en_1,
  input  logic        consumer,
  output csb_data_t   reg_rd_data,
  output logic        op_en_trigger_0,
  output logic        op_en_trigger_1,
  output logic        op_en_wr_value,
  output logic        reg2dp_conv_mode,
  output precision_t  reg2dp_proc_precision
);

  logic          producer;
  logic [1:0]    conv_mode_q;       // per group
  precision_t    precision_q [2];
  logic [1:0]    op_en;
  logic          sel_dual;          // offset in the ping-pong range
  logic [1:0]    sel_grp;           // one-hot producer group
  logic [1:0]    grp_wr_en;         // unlocked write into a group
  logic [1:0]    op_en_trig;
  group_status_e status [2];
  csb_data_t     rd_mux;

  assign op_en = {op_en_1, op_en_0};

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  assign sel_dual  = (reg_offset >= dual_base);
  assign sel_grp   = producer ? 2'b10 : 2'b01;
  assign grp_wr_en = {2{reg_wr_en & sel_dual}} & sel_grp & ~op_en;   // lock mask

  assign op_en_trig      = grp_wr_en & {2{reg_offset == op_enable_offset}};
  assign op_en_trigger_0 = op_en_trig[0];
  assign op_en_trigger_1 = op_en_trig[1];
  assign op_en_wr_value  = reg_wr_data[op_enable_bit];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  // producer pointer, single group
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (reg_wr_en && reg_offset == ptr_offset) begin
      producer <= reg_wr_data[ptr_producer_bit];
    end
  end

  // misc_cfg per group
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      conv_mode_q    <= '0;
      precision_q[0] <= '0;
      precision_q[1] <= '0;
    end else begin
      for (int n = 0; n < 2; n++) begin
        if (grp_wr_en[n] && reg_offset == misc_cfg_offset) begin
          conv_mode_q[n] <= reg_wr_data[cfg_conv_mode_bit];
          precision_q[n] <= reg_wr_data[cfg_prec_lsb +: $bits(precision_t)];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // status and readback
  ////////////////////////////////////////////////////////////
  // pending when the consumer still sits on the other group
  always_comb begin
    for (int n = 0; n < 2; n++) begin
      if (!op_en[n]) begin
        status[n] = status_idle;
      end else if (consumer != 1'(n)) begin
        status[n] = status_pending;
      end else begin
        status[n] = status_running;
      end
    end
  end

  always_comb begin
    rd_mux = '0;   // undefined bits read 0
    case (reg_offset)
      ptr_offset: begin
        rd_mux[ptr_producer_bit] = producer;
        rd_mux[ptr_consumer_bit] = consumer;
      end
      status_offset: begin
        rd_mux[status_0_lsb +: 2] = status[0];
        rd_mux[status_1_lsb +: 2] = status[1];
      end
      op_enable_offset: rd_mux[op_enable_bit] = op_en[producer];
      misc_cfg_offset: begin
        rd_mux[cfg_conv_mode_bit]                     = conv_mode_q[producer];
        rd_mux[cfg_prec_lsb +: $bits(precision_t)] = precision_q[producer];
      end
      default: rd_mux = '0;
    endcase
  end

  assign reg_rd_data = reg_rd_en ? rd_mux : '0;

  // datapath sees the consumer group
  assign reg2dp_conv_mode      = conv_mode_q[consumer];
  assign reg2dp_proc_precision = precision_q[consumer];

  // a group with op_en up keeps its config into the next cycle
  for (genvar g = 0; g < 2; g++) begin : g_lock_chk
    a_locked_cfg_stable : assert property (
      @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      op_en[g] |=> ($stable(conv_mode_q[g]) && $stable(precision_q[g]))
    ) else $error("config of locked group %0d changed", g);
  end

endmodule

`default_nettype wire

// ==== cmac_op_ctrl.sv ====
////////////////////////////////////////////////////////////
// consumer pointer and op_en sequencing
// done flips the consumer and drops op_en of the finished group
// reg2dp_op_en trails by op_en_lat cycles and is flushed on done
// slcg_op_en trails by the same delay and is never flushed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmac_op_ctrl
  import cmac_reg_pkg::*;
#(
  parameter int slcg_num = 4
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                dp2reg_done,
  input  logic                op_en_trigger_0,
  input  logic                op_en_trigger_1,
  input  logic                op_en_wr_value,
  output logic                op_en_0,
  output logic                op_en_1,
  output logic                consumer,
  output logic                reg2dp_op_en,
  output logic [slcg_num-1:0] slcg_op_en
);

  logic [1:0]           trig;
  logic [1:0]           op_en_q;
  logic [1:0]           op_en_nxt;
  logic                 op_en_ori;                 // op_en of consumer group
  logic [op_en_lat-1:0] op_en_sr;
  logic [slcg_num-1:0]  slcg_pipe [op_en_lat];

  assign trig = {op_en_trigger_1, op_en_trigger_0};

  // consumer pointer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp2reg_done) begin
      consumer <= ~consumer;
    end
  end

  // load wins over the done clear
  always_comb begin
    for (int n = 0; n < 2; n++) begin
      if (trig[n] && !op_en_q[n]) begin
        op_en_nxt[n] = op_en_wr_value;
      end else if (dp2reg_done && consumer == 1'(n)) begin
        op_en_nxt[n] = 1'b0;
      end else begin
        op_en_nxt[n] = op_en_q[n];
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_q <= '0;
    end else begin
      op_en_q <= op_en_nxt;
    end
  end

  assign op_en_0   = op_en_q[0];
  assign op_en_1   = op_en_q[1];
  assign op_en_ori = op_en_q[consumer];

  ////////////////////////////////////////////////////////////
  // delay lines
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_sr <= '0;
    end else if (dp2reg_done) begin
      op_en_sr <= '0;   // flush whole line
    end else begin
      op_en_sr <= {op_en_sr[op_en_lat-2:0], op_en_ori};
    end
  end

  assign reg2dp_op_en = op_en_sr[op_en_lat-1];

  // replicated per clock gate
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int i = 0; i < op_en_lat; i++) begin
        slcg_pipe[i] <= '0;
      end
    end else begin
      slcg_pipe[0] <= {slcg_num{op_en_ori}};
      for (int i = 1; i < op_en_lat; i++) begin
        slcg_pipe[i] <= slcg_pipe[i-1];
      end
    end
  end

  assign slcg_op_en = slcg_pipe[op_en_lat-1];

  // done comes from the datapath, must be clean
  a_done_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(dp2reg_done)
  ) else $error("dp2reg_done is X");

endmodule

`default_nettype wire

// ==== cmac_reg_top.sv ====
////////////////////////////////////////////////////////////
// cmac register block top
// csb port feeds the register groups, op control sequences op_en
// req_prdy is tied high, slcg_num sets the clock gate fanout
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmac_reg_top
  import cmac_csb_pkg::*;
  import cmac_reg_pkg::*;
#(
  parameter int slcg_num = 4
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  csb_req_pd_t         csb_req_pd,
  input  logic                csb_req_pvld,
  input  logic                dp2reg_done,
  output logic                csb_req_prdy,
  output csb_resp_pd_t        csb_resp_pd,
  output logic                csb_resp_valid,
  output logic                reg2dp_conv_mode,
  output precision_t          reg2dp_proc_precision,
  output logic                reg2dp_op_en,
  output logic [slcg_num-1:0] slcg_op_en
);

  reg_offset_t reg_offset;
  csb_data_t   reg_wr_data;
  csb_data_t   reg_rd_data;
  logic        reg_wr_en;
  logic        reg_rd_en;
  logic        op_en_trigger_0;
  logic        op_en_trigger_1;
  logic        op_en_wr_value;
  logic        op_en_0;
  logic        op_en_1;
  logic        consumer;

  assign csb_req_prdy = 1'b1;   // never stalls

  cmac_csb_port u_csb_port (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .csb_req_pd      (csb_req_pd),
    .csb_req_pvld    (csb_req_pvld),
    .reg_rd_data     (reg_rd_data),
    .csb_resp_pd     (csb_resp_pd),
    .csb_resp_valid  (csb_resp_valid),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .reg_wr_en       (reg_wr_en),
    .reg_rd_en       (reg_rd_en)
  );

  cmac_reg_groups u_reg_groups (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .reg_offset            (reg_offset),
    .reg_wr_data           (reg_wr_data),
    .reg_wr_en             (reg_wr_en),
    .reg_rd_en             (reg_rd_en),
    .op_en_0               (op_en_0),
    .op_en_1               (op_en_1),
    .consumer              (consumer),
    .reg_rd_data           (reg_rd_data),
    .op_en_trigger_0       (op_en_trigger_0),
    .op_en_trigger_1       (op_en_trigger_1),
    .op_en_wr_value        (op_en_wr_value),
    .reg2dp_conv_mode      (reg2dp_conv_mode),
    .reg2dp_proc_precision (reg2dp_proc_precision)
  );

  cmac_op_ctrl #(
    .slcg_num (slcg_num)
  ) u_op_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dp2reg_done     (dp2reg_done),
    .op_en_trigger_0 (op_en_trigger_0),
    .op_en_trigger_1 (op_en_trigger_1),
    .op_en_wr_value  (op_en_wr_value),
    .op_en_0         (op_en_0),
    .op_en_1         (op_en_1),
    .consumer        (consumer),
    .reg2dp_op_en    (reg2dp_op_en),
    .slcg_op_en      (slcg_op_en)
  );

endmodule

`default_nettype wire

// ==== cmac_reg_checker.sv ====
////////////////////////////////////////////////////////////
// reference model and output checks for the cmac registers
// samples every port at the rising edge, so it sees the
// values of the cycle that just ended
// slcg_num up to 64, values wider than 64 bits not compared
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmac_reg_checker
  import cmac_csb_pkg::*;
  import cmac_reg_pkg::*;
#(
  parameter int slcg_num = 4
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  csb_req_pd_t         csb_req_pd,
  input  logic                csb_req_pvld,
  input  logic                dp2reg_done,
  input  logic                csb_req_prdy,
  input  csb_resp_pd_t        csb_resp_pd,
  input  logic                csb_resp_valid,
  input  logic                reg2dp_conv_mode,
  input  precision_t          reg2dp_proc_precision,
  input  logic                reg2dp_op_en,
  input  logic [slcg_num-1:0] slcg_op_en,
  output int                  mismatch_count,
  output int                  resp_count
);

  // model state
  logic         m_prod;
  logic         m_cons;
  logic [1:0]   m_op_en;
  logic [1:0]   m_conv;
  logic [1:0]   m_prec [2];
  logic         acc_vld;          // request registered at the last edge
  csb_req_pd_t  acc_pd;
  logic         exp_resp_valid;
  csb_resp_pd_t exp_resp_pd;
  logic [2:0]   ori_h;            // [0] newest cycle
  logic [2:0]   done_h;
  // scratch for the access decode
  logic [11:0]  off;
  logic [31:0]  wdat;
  logic         is_wr;
  logic         is_np;
  logic         grp;
  logic [1:0]   trig;

  task automatic compare_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val);
    if (got_val !== exp_val) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp_val, got_val);
    end
  endtask

  // idle, running, or pending while consumer sits on the other group
  function automatic logic [1:0] group_status(input logic en, input logic other);
    if (!en) begin
      return 2'd0;
    end else if (other) begin
      return 2'd2;
    end
    return 2'd1;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] d;
    d = '0;
    case (addr)
      12'h000: begin
        d[0]  = m_prod;
        d[16] = m_cons;
      end
      12'h004: begin
        d[1:0]   = group_status(m_op_en[0], m_cons == 1'b1);
        d[17:16] = group_status(m_op_en[1], m_cons == 1'b0);
      end
      12'h008: d[0] = m_op_en[m_prod];
      12'h00c: begin
        d[0]     = m_conv[m_prod];
        d[13:12] = m_prec[m_prod];
      end
      default: d = '0;   // unmapped
    endcase
    return d;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare, then step the model
  ////////////////////////////////////////////////////////////
  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      m_prod         = 1'b0;
      m_cons         = 1'b0;
      m_op_en        = '0;
      m_conv         = '0;
      m_prec[0]      = '0;
      m_prec[1]      = '0;
      acc_vld        = 1'b0;
      acc_pd         = '0;
      exp_resp_valid = 1'b0;
      exp_resp_pd    = '0;
      ori_h          = '0;
      done_h         = '0;
      mismatch_count = 0;
      resp_count     = 0;
    end else begin
      compare_field("csb_req_prdy", 64'd1, csb_req_prdy);
      compare_field("csb_resp_valid", exp_resp_valid, csb_resp_valid);
      compare_field("csb_resp_pd", exp_resp_pd, csb_resp_pd);   // holds between strobes
      if (exp_resp_valid) begin
        resp_count++;
      end
      compare_field("reg2dp_conv_mode", m_conv[m_cons], reg2dp_conv_mode);
      compare_field("reg2dp_proc_precision", m_prec[m_cons], reg2dp_proc_precision);
      compare_field("reg2dp_op_en", ori_h[2] & ~|done_h, reg2dp_op_en);
      compare_field("slcg_op_en", {slcg_num{ori_h[2]}}, slcg_op_en);

      // access active during the cycle just ended
      off   = {acc_pd[9:0], 2'b00};
      wdat  = acc_pd[53:22];
      is_wr = acc_pd[54];
      is_np = acc_pd[55];
      exp_resp_valid = acc_vld && (!is_wr || is_np);
      if (acc_vld && !is_wr) begin
        exp_resp_pd = {1'b0, 1'b0, model_read(off)};
      end else if (acc_vld && is_np) begin
        exp_resp_pd = {1'b1, 1'b0, 32'h0};
      end

      ori_h  = {ori_h[1:0], m_op_en[m_cons]};
      done_h = {done_h[1:0], dp2reg_done};

      grp  = m_prod;    // group picked before any pointer write lands
      trig = 2'b00;
      if (acc_vld && is_wr) begin
        if (off == 12'h000) begin
          m_prod = wdat[0];
        end
        if (off >= 12'h008 && !m_op_en[grp]) begin   // locked group drops it
          if (off == 12'h008) begin
            trig[grp] = 1'b1;
          end
          if (off == 12'h00c) begin
            m_conv[grp] = wdat[0];
            m_prec[grp] = wdat[13:12];
          end
        end
      end
      for (int n = 0; n < 2; n++) begin
        if (trig[n]) begin
          m_op_en[n] = wdat[0];   // load beats the done clear
        end else if (dp2reg_done && m_cons == 1'(n)) begin
          m_op_en[n] = 1'b0;
        end
      end
      if (dp2reg_done) begin
        m_cons = ~m_cons;
      end
      acc_vld = csb_req_pvld;
      if (csb_req_pvld) begin
        acc_pd = csb_req_pd;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_cmac_reg.sv ====
////////////////////////////////////////////////////////////
// testbench for the cmac register block
// seeded random csb traffic and dp2reg_done pulses
// all comparing lives in cmac_reg_checker, this top only
// drives, bounds the run and reports the final verdict
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cmac_reg
  import cmac_csb_pkg::*;
  import cmac_reg_pkg::*;
();

  localparam int slcg_num     = 4;
  localparam int rst_cycles   = 8;
  localparam int num_cycles   = 3000;
  localparam int drain_cycles = 8;      // let the last responses land
  localparam int cycle_limit  = rst_cycles + num_cycles + 100;

  logic                nvdla_core_clk;
  logic                nvdla_core_rstn;
  csb_req_pd_t         csb_req_pd;
  logic                csb_req_pvld;
  logic                dp2reg_done;
  logic                csb_req_prdy;
  csb_resp_pd_t        csb_resp_pd;
  logic                csb_resp_valid;
  logic                reg2dp_conv_mode;
  precision_t          reg2dp_proc_precision;
  logic                reg2dp_op_en;
  logic [slcg_num-1:0] slcg_op_en;

  integer seed;
  int     cycle_count;
  int     other_errors;
  int     mismatch_count;
  int     resp_count;

  // 4 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  cmac_reg_top #(
    .slcg_num (slcg_num)
  ) u_dut (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .csb_req_pd            (csb_req_pd),
    .csb_req_pvld          (csb_req_pvld),
    .dp2reg_done           (dp2reg_done),
    .csb_req_prdy          (csb_req_prdy),
    .csb_resp_pd           (csb_resp_pd),
    .csb_resp_valid        (csb_resp_valid),
    .reg2dp_conv_mode      (reg2dp_conv_mode),
    .reg2dp_proc_precision (reg2dp_proc_precision),
    .reg2dp_op_en          (reg2dp_op_en),
    .slcg_op_en            (slcg_op_en)
  );

  cmac_reg_checker #(
    .slcg_num (slcg_num)
  ) u_checker (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .csb_req_pd            (csb_req_pd),
    .csb_req_pvld          (csb_req_pvld),
    .dp2reg_done           (dp2reg_done),
    .csb_req_prdy          (csb_req_prdy),
    .csb_resp_pd           (csb_resp_pd),
    .csb_resp_valid        (csb_resp_valid),
    .reg2dp_conv_mode      (reg2dp_conv_mode),
    .reg2dp_proc_precision (reg2dp_proc_precision),
    .reg2dp_op_en          (reg2dp_op_en),
    .slcg_op_en            (slcg_op_en),
    .mismatch_count        (mismatch_count),
    .resp_count            (resp_count)
  );

  // one random beat, all packet fields random, then the word address forced
  task automatic drive_request();
    logic [63:0]  rnd;
    logic [9:0]   word;
    int unsigned  pick;
    csb_req_pd_t  pd;
    rnd  = {$random(seed), $random(seed)};
    pd   = rnd[csb_req_w-1:0];       // upper addr bits stay random, not decoded
    pick = $unsigned($random(seed)) % 5;
    case (pick)
      0: word = 10'h000;   // pointer
      1: word = 10'h001;   // status
      2: word = 10'h002;   // op_enable
      3: word = 10'h003;   // misc_cfg
      default: word = 10'h004 + 10'($unsigned($random(seed)) % 1020);   // unmapped
    endcase
    pd[9:0] = word;
    csb_req_pd   <= pd;
    csb_req_pvld <= ($unsigned($random(seed)) % 4) != 0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed            = 32'h6726addb;
    other_errors    = 0;
    nvdla_core_rstn = 1'b0;
    csb_req_pd      = '0;
    csb_req_pvld    = 1'b0;
    dp2reg_done     = 1'b0;
    repeat (rst_cycles) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    repeat (num_cycles) begin
      @(posedge nvdla_core_clk);
      drive_request();
      dp2reg_done <= ($unsigned($random(seed)) % 20) == 0;   // about 1 in 20
    end
    @(posedge nvdla_core_clk);
    csb_req_pvld <= 1'b0;
    dp2reg_done  <= 1'b0;
    repeat (drain_cycles) @(posedge nvdla_core_clk);
    if (resp_count == 0) begin
      other_errors++;
      $display("error: no csb responses were seen during the run");
    end
    $display("run complete: %0d responses checked, %0d mismatches, %0d other errors",
             resp_count, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge nvdla_core_clk);
      cycle_count++;
    end
    $display("error: run did not finish within %0d cycles", cycle_limit);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
cmac_csb_pkg.sv
cmac_reg_pkg.sv
cmac_csb_port.sv
cmac_reg_groups.sv
cmac_op_ctrl.sv
cmac_reg_top.sv
cmac_reg_checker.sv
tb_cmac_reg.sv

// ==== Bender.yml ====
package:
  name: cmac_reg

sources:
  # packages first
  - cmac_csb_pkg.sv
  - cmac_reg_pkg.sv
  # rtl
  - cmac_csb_port.sv
  - cmac_reg_groups.sv
  - cmac_op_ctrl.sv
  - cmac_reg_top.sv
  # testbench
  - target: simulation
    files:
      - cmac_reg_checker.sv
      - tb_cmac_reg.sv
